/* rtl/camd_cfg.svh */
`ifndef CAMD_CFG_SVH
`define CAMD_CFG_SVH

// byte address width on every command channel.
`define CAMD_ADR_W 32

// ram depth in 32-bit words.
`define CAMD_RAM_WORDS 1024

// single console register.
`define CAMD_CON_ADR 32'h10000000

`endif

/* rtl/camd_pkg.sv */
`default_nettype none

`include "camd_cfg.svh"

package camd_pkg;

   // command beat, one per access.
   typedef struct packed {
      logic                   we;
      logic [`CAMD_ADR_W-1:0] adr;
   } camd_cmd_t;

   // write data beat with byte enables.
   typedef struct packed {
      logic [31:0] dat;
      logic [3:0]  msk;
   } camd_wdat_t;

   typedef logic [31:0] camd_rdat_t;

   // console character.
   typedef logic [7:0] camd_char_t;

endpackage

`default_nettype wire

/* rtl/camd_ram.sv */
`default_nettype none

`include "camd_cfg.svh"

module camd_ram (
   input  wire                   clk,
   input  wire                   i_reset,
   input  wire camd_pkg::camd_cmd_t  i_ca,
   input  wire                   i_ca_vld,
   output logic                  o_ca_rdy,
   input  wire camd_pkg::camd_wdat_t i_dm,
   input  wire                   i_dm_vld,
   output logic                  o_dm_rdy,
   output camd_pkg::camd_rdat_t  o_rd,
   output logic                  o_rd_vld,
   input  wire                   i_rd_rdy
);

   import camd_pkg::*;

   localparam int aw = $clog2(`CAMD_RAM_WORDS);

   logic [31:0]   mem [0:`CAMD_RAM_WORDS-1];

   logic          wr_pend;
   logic [aw-1:0] wr_idx_q;
   logic [aw-1:0] ca_idx;
   logic [aw-1:0] wr_idx;
   logic          ca_go;
   logic          dm_go;
   logic          rd_take;
   logic          rd_stall;
   camd_rdat_t    rd_q;
   logic          rd_vld_q;

   // word index from the byte address.
   assign ca_idx = i_ca.adr[aw+1:2];

   assign rd_take  = rd_vld_q & i_rd_rdy;
   assign rd_stall = rd_vld_q & !i_rd_rdy;

   // one access at a time, and a held read word blocks the next command.
   assign o_ca_rdy = !wr_pend & !rd_stall;
   assign ca_go    = i_ca_vld & o_ca_rdy;

   // data is taken with its command or any cycle after.
   assign o_dm_rdy = wr_pend | (ca_go & i_ca.we);
   assign dm_go    = i_dm_vld & o_dm_rdy;

   assign wr_idx = wr_pend ? wr_idx_q : ca_idx;

   assign o_rd     = rd_q;
   assign o_rd_vld = rd_vld_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_pend  <= 1'b0;
         rd_vld_q <= 1'b0;
      end else begin
         if (dm_go) begin
            wr_pend <= 1'b0;
         end else if (ca_go & i_ca.we) begin
            wr_pend <= 1'b1;
         end

         if (ca_go & !i_ca.we) begin
            rd_vld_q <= 1'b1;
         end else if (rd_take) begin
            rd_vld_q <= 1'b0;
         end
      end
   end

   // address and read word.
   always_ff @(posedge clk) begin
      if (ca_go & i_ca.we) begin
         wr_idx_q <= ca_idx;
      end
      if (ca_go & !i_ca.we) begin
         rd_q <= mem[ca_idx];
      end
   end

   // byte lanes written where the mask is set.
   always_ff @(posedge clk) begin
      if (dm_go) begin
         for (int b = 0; b < 4; b++) begin
            if (i_dm.msk[b]) begin
               mem[wr_idx][8*b +: 8] <= i_dm.dat[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/camd_console.sv */
`default_nettype none

module camd_console (
   input  wire                   clk,
   input  wire                   i_reset,
   input  wire camd_pkg::camd_cmd_t  i_ca,
   input  wire                   i_ca_vld,
   output logic                  o_ca_rdy,
   input  wire camd_pkg::camd_wdat_t i_dm,
   input  wire                   i_dm_vld,
   output logic                  o_dm_rdy,
   output camd_pkg::camd_rdat_t  o_rd,
   output logic                  o_rd_vld,
   input  wire                   i_rd_rdy,
   output camd_pkg::camd_char_t  o_char,
   output logic                  o_char_vld,
   input  wire                   i_char_rdy
);

   import camd_pkg::*;

   logic       wr_pend;
   logic       ca_go;
   logic       dm_go;
   logic       char_go;
   logic       char_full;
   camd_char_t char_q;
   logic       char_vld_q;
   camd_rdat_t count;
   camd_rdat_t rd_q;
   logic       rd_vld_q;

   assign o_ca_rdy = !wr_pend & !(rd_vld_q & !i_rd_rdy);
   assign ca_go    = i_ca_vld & o_ca_rdy;

   // a full, stalled character register holds off the data beat.
   assign char_full = char_vld_q & !i_char_rdy;
   assign o_dm_rdy  = (wr_pend | (ca_go & i_ca.we)) & !char_full;
   assign dm_go     = i_dm_vld & o_dm_rdy;
   assign char_go   = char_vld_q & i_char_rdy;

   assign o_char     = char_q;
   assign o_char_vld = char_vld_q;
   assign o_rd       = rd_q;
   assign o_rd_vld   = rd_vld_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_pend    <= 1'b0;
         char_vld_q <= 1'b0;
         rd_vld_q   <= 1'b0;
         count      <= '0;
      end else begin
         if (dm_go) begin
            wr_pend <= 1'b0;
         end else if (ca_go & i_ca.we) begin
            wr_pend <= 1'b1;
         end

         // beats without byte 0 are dropped.
         if (dm_go & i_dm.msk[0]) begin
            char_vld_q <= 1'b1;
         end else if (char_go) begin
            char_vld_q <= 1'b0;
         end

         if (char_go) begin
            count <= count + 32'd1;
         end

         if (ca_go & !i_ca.we) begin
            rd_vld_q <= 1'b1;
         end else if (rd_vld_q & i_rd_rdy) begin
            rd_vld_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dm_go & i_dm.msk[0]) begin
         char_q <= i_dm.dat[7:0];
      end
      if (ca_go & !i_ca.we) begin
         rd_q <= count;
      end
   end

endmodule

`default_nettype wire

/* rtl/camd_decode.sv */
`default_nettype none

`include "camd_cfg.svh"

module camd_decode (
   input  wire                   clk,
   input  wire                   i_reset,
   input  wire camd_pkg::camd_cmd_t  i_ca,
   input  wire                   i_ca_vld,
   output logic                  o_ca_rdy,
   input  wire camd_pkg::camd_wdat_t i_dm,
   input  wire                   i_dm_vld,
   output logic                  o_dm_rdy,
   output camd_pkg::camd_rdat_t  o_rd,
   output logic                  o_rd_vld,
   input  wire                   i_rd_rdy,
   output camd_pkg::camd_cmd_t   o_ram_ca,
   output logic                  o_ram_ca_vld,
   input  wire                   i_ram_ca_rdy,
   output camd_pkg::camd_wdat_t  o_ram_dm,
   output logic                  o_ram_dm_vld,
   input  wire                   i_ram_dm_rdy,
   input  wire camd_pkg::camd_rdat_t i_ram_rd,
   input  wire                   i_ram_rd_vld,
   output logic                  o_ram_rd_rdy,
   output camd_pkg::camd_cmd_t   o_con_ca,
   output logic                  o_con_ca_vld,
   input  wire                   i_con_ca_rdy,
   output camd_pkg::camd_wdat_t  o_con_dm,
   output logic                  o_con_dm_vld,
   input  wire                   i_con_dm_rdy,
   input  wire camd_pkg::camd_rdat_t i_con_rd,
   input  wire                   i_con_rd_vld,
   output logic                  o_con_rd_rdy
);

   import camd_pkg::*;

   logic is_con;
   logic blocked;
   logic ca_go;
   logic dm_route;
   logic dm_con;
   logic dm_go;
   logic wr_pend;
   logic wr_tgt;
   logic rd_busy;
   logic rd_tgt;

   assign is_con  = (i_ca.adr == `CAMD_CON_ADR);
   assign blocked = rd_busy | wr_pend;

   assign o_ram_ca     = i_ca;
   assign o_con_ca     = i_ca;
   assign o_ram_ca_vld = i_ca_vld & !blocked & !is_con;
   assign o_con_ca_vld = i_ca_vld & !blocked & is_con;
   assign o_ca_rdy     = !blocked & (is_con ? i_con_ca_rdy : i_ram_ca_rdy);
   assign ca_go        = i_ca_vld & o_ca_rdy;

   // beat goes with its command, or to the recorded target later.
   assign dm_route     = wr_pend | (ca_go & i_ca.we);
   assign dm_con       = wr_pend ? wr_tgt : is_con;
   assign o_ram_dm     = i_dm;
   assign o_con_dm     = i_dm;
   assign o_ram_dm_vld = i_dm_vld & dm_route & !dm_con;
   assign o_con_dm_vld = i_dm_vld & dm_route & dm_con;
   assign o_dm_rdy     = dm_route & (dm_con ? i_con_dm_rdy : i_ram_dm_rdy);
   assign dm_go        = i_dm_vld & o_dm_rdy;

   // only the read in flight is passed back.
   assign o_rd         = rd_tgt ? i_con_rd : i_ram_rd;
   assign o_rd_vld     = rd_busy & (rd_tgt ? i_con_rd_vld : i_ram_rd_vld);
   assign o_ram_rd_rdy = i_rd_rdy & rd_busy & !rd_tgt;
   assign o_con_rd_rdy = i_rd_rdy & rd_busy & rd_tgt;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_pend <= 1'b0;
         wr_tgt  <= 1'b0;
         rd_busy <= 1'b0;
         rd_tgt  <= 1'b0;
      end else begin
         if (dm_go) begin
            wr_pend <= 1'b0;
         end else if (ca_go & i_ca.we) begin
            wr_pend <= 1'b1;
            wr_tgt  <= is_con;
         end

         if (ca_go & !i_ca.we) begin
            rd_busy <= 1'b1;
            rd_tgt  <= is_con;
         end else if (o_rd_vld & i_rd_rdy) begin
            rd_busy <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/camd_subsys_top.sv */
`default_nettype none

module camd_subsys_top (
   input  wire                   clk,
   input  wire                   i_reset,
   input  wire camd_pkg::camd_cmd_t  i_ca,
   input  wire                   i_ca_vld,
   output wire                   o_ca_rdy,
   input  wire camd_pkg::camd_wdat_t i_dm,
   input  wire                   i_dm_vld,
   output wire                   o_dm_rdy,
   output wire camd_pkg::camd_rdat_t o_rd,
   output wire                   o_rd_vld,
   input  wire                   i_rd_rdy,
   output wire camd_pkg::camd_char_t o_char,
   output wire                   o_char_vld,
   input  wire                   i_char_rdy
);

   import camd_pkg::*;

   // ram side.
   wire camd_cmd_t  ram_ca;
   wire             ram_ca_vld;
   wire             ram_ca_rdy;
   wire camd_wdat_t ram_dm;
   wire             ram_dm_vld;
   wire             ram_dm_rdy;
   wire camd_rdat_t ram_rd;
   wire             ram_rd_vld;
   wire             ram_rd_rdy;

   // console side.
   wire camd_cmd_t  con_ca;
   wire             con_ca_vld;
   wire             con_ca_rdy;
   wire camd_wdat_t con_dm;
   wire             con_dm_vld;
   wire             con_dm_rdy;
   wire camd_rdat_t con_rd;
   wire             con_rd_vld;
   wire             con_rd_rdy;

   camd_decode camd_decode_inst (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_ca         (i_ca),
      .i_ca_vld     (i_ca_vld),
      .o_ca_rdy     (o_ca_rdy),
      .i_dm         (i_dm),
      .i_dm_vld     (i_dm_vld),
      .o_dm_rdy     (o_dm_rdy),
      .o_rd         (o_rd),
      .o_rd_vld     (o_rd_vld),
      .i_rd_rdy     (i_rd_rdy),
      .o_ram_ca     (ram_ca),
      .o_ram_ca_vld (ram_ca_vld),
      .i_ram_ca_rdy (ram_ca_rdy),
      .o_ram_dm     (ram_dm),
      .o_ram_dm_vld (ram_dm_vld),
      .i_ram_dm_rdy (ram_dm_rdy),
      .i_ram_rd     (ram_rd),
      .i_ram_rd_vld (ram_rd_vld),
      .o_ram_rd_rdy (ram_rd_rdy),
      .o_con_ca     (con_ca),
      .o_con_ca_vld (con_ca_vld),
      .i_con_ca_rdy (con_ca_rdy),
      .o_con_dm     (con_dm),
      .o_con_dm_vld (con_dm_vld),
      .i_con_dm_rdy (con_dm_rdy),
      .i_con_rd     (con_rd),
      .i_con_rd_vld (con_rd_vld),
      .o_con_rd_rdy (con_rd_rdy)
   );

   camd_ram camd_ram_inst (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_ca     (ram_ca),
      .i_ca_vld (ram_ca_vld),
      .o_ca_rdy (ram_ca_rdy),
      .i_dm     (ram_dm),
      .i_dm_vld (ram_dm_vld),
      .o_dm_rdy (ram_dm_rdy),
      .o_rd     (ram_rd),
      .o_rd_vld (ram_rd_vld),
      .i_rd_rdy (ram_rd_rdy)
   );

   camd_console camd_console_inst (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ca       (con_ca),
      .i_ca_vld   (con_ca_vld),
      .o_ca_rdy   (con_ca_rdy),
      .i_dm       (con_dm),
      .i_dm_vld   (con_dm_vld),
      .o_dm_rdy   (con_dm_rdy),
      .o_rd       (con_rd),
      .o_rd_vld   (con_rd_vld),
      .i_rd_rdy   (con_rd_rdy),
      .o_char     (o_char),
      .o_char_vld (o_char_vld),
      .i_char_rdy (i_char_rdy)
   );

endmodule

`default_nettype wire

/* tb/camd_subsys_assert.sv */
`default_nettype none

module camd_subsys_assert (
   input wire                       clk,
   input wire                       i_reset,
   input wire camd_pkg::camd_rdat_t o_rd,
   input wire                       o_rd_vld,
   input wire                       i_rd_rdy,
   input wire camd_pkg::camd_char_t o_char,
   input wire                       o_char_vld,
   input wire                       i_char_rdy
);

   // read word held until taken.
   rd_hold_a: assert property (@(posedge clk) disable iff (i_reset)
      o_rd_vld && !i_rd_rdy |=> o_rd_vld && $stable(o_rd))
      else $error("read data dropped or changed before it was taken");

   char_hold_a: assert property (@(posedge clk) disable iff (i_reset)
      o_char_vld && !i_char_rdy |=> o_char_vld && $stable(o_char))
      else $error("console character dropped or changed before it was taken");

   // both streams idle once reset has been seen.
   reset_a: assert property (@(posedge clk) i_reset |=> !o_rd_vld && !o_char_vld)
      else $error("output valid high in the cycle after reset");

endmodule

bind camd_subsys_top camd_subsys_assert camd_subsys_assert_inst (
   .clk        (clk),
   .i_reset    (i_reset),
   .o_rd       (o_rd),
   .o_rd_vld   (o_rd_vld),
   .i_rd_rdy   (i_rd_rdy),
   .o_char     (o_char),
   .o_char_vld (o_char_vld),
   .i_char_rdy (i_char_rdy)
);

`default_nettype wire

/* tb/camd_subsys_tb.sv */
`default_nettype none

`include "camd_cfg.svh"

module camd_subsys_tb;

   import camd_pkg::*;

   localparam int max_rec = 64;

   logic        clk = 1'b0;
   logic        reset;
   camd_cmd_t   ca;
   logic        ca_vld;
   logic        ca_rdy;
   camd_wdat_t  dm;
   logic        dm_vld;
   logic        dm_rdy;
   camd_rdat_t  rd;
   logic        rd_vld;
   logic        rd_rdy;
   camd_char_t  chr;
   logic        chr_vld;
   logic        chr_rdy;

   logic [31:0] stim [0:5*max_rec-1];
   int          n_rec = 0;
   integer      seed = 32'h6beb;
   int          mismatch_cnt = 0;
   int          fault_cnt = 0;
   int          rd_checked = 0;
   int          chr_checked = 0;
   camd_rdat_t  chars_taken;

   // expected read words and characters, oldest first.
   camd_rdat_t  exp_rd_q[$];
   string       rd_name_q[$];
   camd_char_t  exp_chr_q[$];
   string       chr_name_q[$];

   always #4 clk = ~clk;

   camd_subsys_top camd_subsys_top_inst (
      .clk        (clk),
      .i_reset    (reset),
      .i_ca       (ca),
      .i_ca_vld   (ca_vld),
      .o_ca_rdy   (ca_rdy),
      .i_dm       (dm),
      .i_dm_vld   (dm_vld),
      .o_dm_rdy   (dm_rdy),
      .o_rd       (rd),
      .o_rd_vld   (rd_vld),
      .i_rd_rdy   (rd_rdy),
      .o_char     (chr),
      .o_char_vld (chr_vld),
      .i_char_rdy (chr_rdy)
   );

   task automatic check_rd(input string name, input camd_rdat_t exp, input camd_rdat_t act);
      rd_checked++;
      if (act !== exp) begin
         mismatch_cnt++;
         $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_char(input string name, input camd_char_t exp, input camd_char_t act);
      chr_checked++;
      if (act !== exp) begin
         mismatch_cnt++;
         $display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
      end
   endtask

   // command first, data beat gap cycles after the command is taken.
   task automatic send_write(input string name, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] msk, input int gap);
      bit ca_done;
      bit dm_done;
      int wait_n;
      ca_done = 1'b0;
      dm_done = 1'b0;
      wait_n  = gap;
      if (adr == `CAMD_CON_ADR && msk[0]) begin
         exp_chr_q.push_back(dat[7:0]);
         chr_name_q.push_back(name);
      end
      ca.we  = 1'b1;
      ca.adr = adr;
      ca_vld = 1'b1;
      dm.dat = dat;
      dm.msk = msk;
      dm_vld = (gap == 0);
      while (!(ca_done && dm_done)) begin
         @(posedge clk);
         if (ca_vld && ca_rdy) begin
            ca_done = 1'b1;
         end
         if (dm_vld && dm_rdy) begin
            dm_done = 1'b1;
         end
         @(negedge clk);
         if (ca_done) begin
            ca_vld = 1'b0;
         end
         if (dm_done) begin
            dm_vld = 1'b0;
         end else if (ca_done && !dm_vld) begin
            if (wait_n <= 1) begin
               dm_vld = 1'b1;
            end else begin
               wait_n--;
            end
         end
      end
   endtask

   task automatic send_read(input string name, input logic [31:0] adr, input logic [31:0] exp);
      bit done;
      done   = 1'b0;
      ca.we  = 1'b0;
      ca.adr = adr;
      ca_vld = 1'b1;
      while (!done) begin
         @(posedge clk);
         if (ca_vld && ca_rdy) begin
            done = 1'b1;
            // console count as of the accepting edge.
            if (adr == `CAMD_CON_ADR) begin
               exp_rd_q.push_back(chars_taken);
            end else begin
               exp_rd_q.push_back(exp);
            end
            rd_name_q.push_back(name);
         end
         @(negedge clk);
         if (done) begin
            ca_vld = 1'b0;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!reset && rd_vld && rd_rdy) begin
         if (exp_rd_q.size() == 0) begin
            fault_cnt++;
            $display("read word %08h came back with no read outstanding", rd);
         end else begin
            check_rd(rd_name_q.pop_front(), exp_rd_q.pop_front(), rd);
         end
      end
   end

   always @(posedge clk) begin
      if (reset) begin
         chars_taken <= '0;
      end else if (chr_vld && chr_rdy) begin
         chars_taken <= chars_taken + 32'd1;
         if (exp_chr_q.size() == 0) begin
            fault_cnt++;
            $display("console emitted character %02h that no write asked for", chr);
         end else begin
            check_char(chr_name_q.pop_front(), exp_chr_q.pop_front(), chr);
         end
      end
   end

   // random back-pressure on both output streams.
   initial begin
      integer rnd;
      rd_rdy  = 1'b0;
      chr_rdy = 1'b0;
      forever begin
         @(negedge clk);
         rnd     = $random(seed);
         rd_rdy  = (rnd[1:0] != 2'b00);
         chr_rdy = (rnd[3:2] != 2'b00);
      end
   end

   initial begin
      wait (n_rec != 0);
      repeat (40 * n_rec) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", 40 * n_rec);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int          k;
      logic [31:0] kind;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  msk;
      logic [31:0] arg;
      reset  = 1'b1;
      ca     = '0;
      ca_vld = 1'b0;
      dm     = '0;
      dm_vld = 1'b0;
      for (k = 0; k < 5 * max_rec; k++) begin
         stim[k] = '0;
      end
      $readmemh("tb/camd_stim.txt", stim);
      while (n_rec < max_rec && stim[5*n_rec] != 32'd0) begin
         n_rec++;
      end
      repeat (2) @(negedge clk);
      reset = 1'b0;

      for (k = 0; k < n_rec; k++) begin
         kind = stim[5*k];
         adr  = stim[5*k+1];
         dat  = stim[5*k+2];
         msk  = stim[5*k+3][3:0];
         arg  = stim[5*k+4];
         case (kind)
            32'd1: send_write($sformatf("rec%0d write %08h", k, adr), adr, dat, msk, arg);
            32'd2: send_read($sformatf("rec%0d read %08h", k, adr), adr, arg);
            32'd3: repeat (arg) @(negedge clk);
            default: begin
               fault_cnt++;
               $display("stim record %0d has an unknown kind %0h", k, kind);
            end
         endcase
      end

      // drain, then a few quiet cycles to catch stray outputs.
      while (exp_rd_q.size() != 0 || exp_chr_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (8) @(negedge clk);

      $display("errors: %0d mismatches, %0d other; %0d reads and %0d characters checked",
               mismatch_cnt, fault_cnt, rd_checked, chr_checked);
      if (mismatch_cnt == 0 && fault_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/camd_stim.txt */
// columns: kind adr dat msk exp, hex. kind 1 write, 2 read, 3 idle, 0 end.
// exp is the ram read word, the write beat delay or the idle cycles; console reads ignore it.
1 00000000 11223344 f 00000000
1 00000004 a5a5a5a5 f 00000002
2 00000000 00000000 0 11223344
2 00000004 00000000 0 a5a5a5a5
1 00000000 ffeeddcc 1 00000000
1 00000000 99887766 4 00000003
1 00000ffc 01020304 f 00000000
1 00000ffc aabbccdd 6 00000001
2 00000000 00000000 0 118833cc
2 00000ffc 00000000 0 01bbcc04
2 00000004 00000000 0 a5a5a5a5
1 10000000 00000048 1 00000000
1 10000000 00000069 1 00000004
1 10000000 00000021 e 00000000
1 10000000 0000000a f 00000001
2 10000000 00000000 0 00000000
3 00000000 00000000 0 00000010
2 10000000 00000000 0 00000000
1 00000008 cafef00d f 00000005
2 00000008 00000000 0 cafef00d
0 00000000 00000000 0 00000000

/* camd_subsys.f */
+incdir+rtl
rtl/camd_pkg.sv
rtl/camd_ram.sv
rtl/camd_console.sv
rtl/camd_decode.sv
rtl/camd_subsys_top.sv
tb/camd_subsys_assert.sv
tb/camd_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root.
verilator --binary --timing --assert --top-module camd_subsys_tb \
   -f camd_subsys.f -o camd_sim || exit 1
./obj_dir/camd_sim > sim.log 2>&1 \
   || echo "simulator stopped early: TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
